// File: design/apb_pkg.sv
package apb_pkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] apb_addr_t;
    typedef logic [DATA_W-1:0] apb_data_t;

    // enable mask in [3:0], resets to all enabled
    localparam apb_addr_t REG_CTRL   = 8'h00;

    // sticky overflow flags in [3:0], write 1 to clear
    localparam apb_addr_t REG_STATUS = 8'h04;

    // 4-bit fill level per channel, channel 0 in [3:0], read only
    localparam apb_addr_t REG_LEVEL  = 8'h08;

    // wrapping count of popped bytes, read only
    localparam apb_addr_t REG_POPS   = 8'h0C;

    // field width of one level entry in REG_LEVEL
    localparam int LEVEL_FIELD_W = 4;

endpackage

// File: design/apb_regs.sv
`timescale 1ns/1ps

module apb_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  apb_pkg::apb_addr_t   paddr,
    input  apb_pkg::apb_data_t   pwdata,
    input  arb_cfg_pkg::mask_t   overflow,
    input  arb_cfg_pkg::mask_t   pop,
    input  arb_cfg_pkg::level_t  level_0,
    input  arb_cfg_pkg::level_t  level_1,
    input  arb_cfg_pkg::level_t  level_2,
    input  arb_cfg_pkg::level_t  level_3,
    output apb_pkg::apb_data_t   prdata,
    output logic                 pready,
    output logic                 pslverr,
    output arb_cfg_pkg::mask_t   enable
);

    localparam int NC = arb_cfg_pkg::NUM_CHAN;
    localparam int LW = apb_pkg::LEVEL_FIELD_W;

    arb_cfg_pkg::mask_t ovf_flags;
    arb_cfg_pkg::mask_t ovf_clr;
    apb_pkg::apb_data_t pop_cnt;
    apb_pkg::apb_data_t level_word;
    logic               access;
    logic               wr;
    logic               mapped;

    assign access = psel && penable;
    assign wr     = access && pwrite;

    assign mapped = (paddr == apb_pkg::REG_CTRL)  || (paddr == apb_pkg::REG_STATUS) ||
                    (paddr == apb_pkg::REG_LEVEL) || (paddr == apb_pkg::REG_POPS);

    assign pready  = 1'b1; // zero wait states
    assign pslverr = access && !mapped;

    assign level_word = {{(apb_pkg::DATA_W - NC * LW){1'b0}},
                         level_3, level_2, level_1, level_0};

    always_comb begin
        case (paddr)
            apb_pkg::REG_CTRL:   prdata = apb_pkg::apb_data_t'(enable);
            apb_pkg::REG_STATUS: prdata = apb_pkg::apb_data_t'(ovf_flags);
            apb_pkg::REG_LEVEL:  prdata = level_word;
            apb_pkg::REG_POPS:   prdata = pop_cnt;
            default:             prdata = '0;
        endcase
    end

    // write-1-to-clear mask for the sticky flags
    assign ovf_clr = (wr && (paddr == apb_pkg::REG_STATUS)) ?
                     arb_cfg_pkg::mask_t'(pwdata[NC-1:0]) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable <= '1;
        end else if (wr && (paddr == apb_pkg::REG_CTRL)) begin
            enable <= arb_cfg_pkg::mask_t'(pwdata[NC-1:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ovf_flags <= '0;
        end else begin
            ovf_flags <= (ovf_flags & ~ovf_clr) | overflow; // new overflow beats clear
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pop_cnt <= '0;
        end else if (|pop) begin
            pop_cnt <= pop_cnt + 1'b1; // wraps
        end
    end

    // access phase only follows a selected setup phase
    a_penable_psel: assert property (
        @(posedge clk) disable iff (!rst_n)
        penable |-> psel
    ) else $error("apb_regs: penable without psel");

endmodule

// File: design/arb_cfg_pkg.sv
package arb_cfg_pkg;

    // four-way rotation fixes the channel count
    localparam int NUM_CHAN = 4;

    localparam int DATA_W  = 8;
    localparam int CHAN_W  = $clog2(NUM_CHAN);
    localparam int LEVEL_W = 4; // room for DEPTH up to 15

    // one queued byte
    typedef logic [DATA_W-1:0] data_t;

    // channel index as carried on out_chan
    typedef logic [CHAN_W-1:0] chan_t;

    // one bit per channel: write enables, enable mask, overflow, pops
    typedef logic [NUM_CHAN-1:0] mask_t;

    // queue occupancy
    typedef logic [LEVEL_W-1:0] level_t;

endpackage

// File: design/chan_fifo.sv
`timescale 1ns/1ps

module chan_fifo #(
    parameter int DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wen,
    input  arb_cfg_pkg::data_t   din,
    input  logic                 pop,
    output arb_cfg_pkg::data_t   head,
    output arb_cfg_pkg::level_t  level,
    output logic                 overflow
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [PTR_W-1:0] ptr_t;

    arb_cfg_pkg::data_t  mem [DEPTH];
    ptr_t                wr_ptr;
    ptr_t                rd_ptr;
    ptr_t                wr_ptr_nxt;
    ptr_t                rd_ptr_nxt;
    arb_cfg_pkg::level_t count;
    logic                full;
    logic                wr_ok;

    assign full  = (count == arb_cfg_pkg::level_t'(DEPTH));
    assign wr_ok = wen && !full;

    // pointers wrap at DEPTH, which need not be a power of two
    assign wr_ptr_nxt = (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    assign rd_ptr_nxt = (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr_nxt;
            end
            if (pop) begin
                rd_ptr <= rd_ptr_nxt; // selector already checked occupancy
            end
            case ({wr_ok, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head     = mem[rd_ptr];
    assign level    = count;
    assign overflow = wen && full; // byte dropped this edge

    // selector must never pop an empty queue or a channel that is writing
    a_pop_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> (count != '0) && !wen
    ) else $error("chan_fifo: illegal pop, level %0d wen %0b", count, wen);

endmodule

// File: design/rr_fifo_arbiter.sv
`timescale 1ns/1ps

module rr_fifo_arbiter #(
    parameter int DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  arb_cfg_pkg::mask_t   wen,
    input  arb_cfg_pkg::data_t   din_0,
    input  arb_cfg_pkg::data_t   din_1,
    input  arb_cfg_pkg::data_t   din_2,
    input  arb_cfg_pkg::data_t   din_3,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  apb_pkg::apb_addr_t   paddr,
    input  apb_pkg::apb_data_t   pwdata,
    output logic                 out_valid,
    output arb_cfg_pkg::data_t   out_data,
    output arb_cfg_pkg::chan_t   out_chan,
    output apb_pkg::apb_data_t   prdata,
    output logic                 pready,
    output logic                 pslverr
);

    arb_cfg_pkg::data_t  din_a   [arb_cfg_pkg::NUM_CHAN];
    arb_cfg_pkg::data_t  head_a  [arb_cfg_pkg::NUM_CHAN];
    arb_cfg_pkg::level_t level_a [arb_cfg_pkg::NUM_CHAN];
    arb_cfg_pkg::mask_t  pop;
    arb_cfg_pkg::mask_t  overflow;
    arb_cfg_pkg::mask_t  enable;

    assign din_a = '{din_0, din_1, din_2, din_3};

    // stage 1, one queue per channel
    for (genvar i = 0; i < arb_cfg_pkg::NUM_CHAN; i++) begin : g_fifo
        chan_fifo #(.DEPTH(DEPTH)) u_fifo (
            .clk(clk), .rst_n(rst_n),
            .wen(wen[i]), .din(din_a[i]), .pop(pop[i]),
            .head(head_a[i]), .level(level_a[i]), .overflow(overflow[i])
        );
    end

    // stage 2, pointer and output register
    rr_select u_sel (
        .clk(clk), .rst_n(rst_n), .wen(wen), .enable(enable),
        .level_0(level_a[0]), .level_1(level_a[1]),
        .level_2(level_a[2]), .level_3(level_a[3]),
        .head_0(head_a[0]), .head_1(head_a[1]),
        .head_2(head_a[2]), .head_3(head_a[3]),
        .pop(pop), .out_valid(out_valid), .out_data(out_data), .out_chan(out_chan)
    );

    apb_regs u_regs (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .overflow(overflow), .pop(pop),
        .level_0(level_a[0]), .level_1(level_a[1]),
        .level_2(level_a[2]), .level_3(level_a[3]),
        .prdata(prdata), .pready(pready), .pslverr(pslverr), .enable(enable)
    );

endmodule

// File: design/rr_select.sv
`timescale 1ns/1ps

module rr_select (
    input  logic                 clk,
    input  logic                 rst_n,
    input  arb_cfg_pkg::mask_t   wen,
    input  arb_cfg_pkg::mask_t   enable,
    input  arb_cfg_pkg::level_t  level_0,
    input  arb_cfg_pkg::level_t  level_1,
    input  arb_cfg_pkg::level_t  level_2,
    input  arb_cfg_pkg::level_t  level_3,
    input  arb_cfg_pkg::data_t   head_0,
    input  arb_cfg_pkg::data_t   head_1,
    input  arb_cfg_pkg::data_t   head_2,
    input  arb_cfg_pkg::data_t   head_3,
    output arb_cfg_pkg::mask_t   pop,
    output logic                 out_valid,
    output arb_cfg_pkg::data_t   out_data,
    output arb_cfg_pkg::chan_t   out_chan
);

    arb_cfg_pkg::chan_t  ptr;
    arb_cfg_pkg::level_t lvl [arb_cfg_pkg::NUM_CHAN];
    arb_cfg_pkg::data_t  hd  [arb_cfg_pkg::NUM_CHAN];
    logic                take;

    assign lvl = '{level_0, level_1, level_2, level_3};
    assign hd  = '{head_0, head_1, head_2, head_3};

    // free-running pointer, 0 in the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else begin
            ptr <= ptr + 1'b1;
        end
    end

    // a writing channel loses its turn
    assign take = (lvl[ptr] != '0) && enable[ptr] && !wen[ptr];

    always_comb begin
        pop      = '0;
        pop[ptr] = take;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= take;
        end
    end

    // payload only loads on a pop
    always_ff @(posedge clk) begin
        if (take) begin
            out_data <= hd[ptr];
            out_chan <= ptr;
        end
    end

    // a reported byte must come from a channel that was enabled at pop time
    a_out_enabled: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> |($past(enable) & (arb_cfg_pkg::mask_t'(1) << out_chan))
    ) else $error("rr_select: output from disabled channel %0d", out_chan);

endmodule

// File: rr_fifo_arbiter.f
design/arb_cfg_pkg.sv
design/apb_pkg.sv
design/chan_fifo.sv
design/rr_select.sv
design/apb_regs.sv
design/rr_fifo_arbiter.sv
testbench/tb_rr_fifo_arbiter.sv

// File: testbench/tb_rr_fifo_arbiter.sv
`timescale 1ns/1ps

module tb_rr_fifo_arbiter;

    localparam int DEPTH = 8;
    localparam int NC    = arb_cfg_pkg::NUM_CHAN;
    localparam int RST_CYCLES = 10;

    localparam logic [1:0] OP_NONE     = 2'd0;
    localparam logic [1:0] OP_WRITE    = 2'd1;
    localparam logic [1:0] OP_READ     = 2'd2; // expected value from the model
    localparam logic [1:0] OP_READ_FIX = 2'd3; // expected value from the table

    typedef struct packed {
        arb_cfg_pkg::mask_t wen;
        logic [31:0]        din; // channel 0 in [7:0]
        logic [1:0]         op;
        apb_pkg::apb_addr_t addr;
        apb_pkg::apb_data_t wdata;
        apb_pkg::apb_data_t exp;
        logic               exp_err;
    } row_t;

    logic                clk;
    logic                rst_n;
    arb_cfg_pkg::mask_t  wen;
    arb_cfg_pkg::data_t  din_0;
    arb_cfg_pkg::data_t  din_1;
    arb_cfg_pkg::data_t  din_2;
    arb_cfg_pkg::data_t  din_3;
    logic                psel;
    logic                penable;
    logic                pwrite;
    apb_pkg::apb_addr_t  paddr;
    apb_pkg::apb_data_t  pwdata;
    logic                out_valid;
    arb_cfg_pkg::data_t  out_data;
    arb_cfg_pkg::chan_t  out_chan;
    apb_pkg::apb_data_t  prdata;
    logic                pready;
    logic                pslverr;

    row_t rows[$];
    int   errors;
    int   cycle_cnt;
    int   max_cycles;

    // reference model state
    arb_cfg_pkg::data_t  m_buf [NC][DEPTH];
    int                  m_head [NC];
    int                  m_cnt [NC];
    arb_cfg_pkg::chan_t  m_ptr;
    arb_cfg_pkg::mask_t  m_en;
    arb_cfg_pkg::mask_t  m_ovf;
    apb_pkg::apb_data_t  m_pops;
    logic                exp_valid;
    arb_cfg_pkg::data_t  exp_data;
    arb_cfg_pkg::chan_t  exp_chan;

    rr_fifo_arbiter #(.DEPTH(DEPTH)) dut (
        .clk(clk), .rst_n(rst_n), .wen(wen),
        .din_0(din_0), .din_1(din_1), .din_2(din_2), .din_3(din_3),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .out_valid(out_valid), .out_data(out_data), .out_chan(out_chan),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #2 clk = ~clk;

    task automatic fail_now();
        errors++;
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input arb_cfg_pkg::data_t got,
                              input arb_cfg_pkg::data_t exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_chan(input string name, input arb_cfg_pkg::chan_t got,
                              input arb_cfg_pkg::chan_t exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_apb(input string name, input apb_pkg::apb_data_t got,
                             input apb_pkg::apb_data_t exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            fail_now();
        end
    endtask

    function automatic row_t blank_row();
        row_t r;
        r     = '0;
        r.din = $urandom; // four random bytes
        return r;
    endfunction

    task automatic idle_cycles(input int n);
        for (int k = 0; k < n; k++) begin
            rows.push_back(blank_row());
        end
    endtask

    task automatic write_burst(input arb_cfg_pkg::mask_t mask, input int n);
        row_t r;
        for (int k = 0; k < n; k++) begin
            r     = blank_row();
            r.wen = mask;
            rows.push_back(r);
        end
    endtask

    task automatic random_writes(input int n);
        for (int k = 0; k < n; k++) begin
            write_burst(arb_cfg_pkg::mask_t'($urandom), 1);
        end
    endtask

    // each access gets a quiet row in front for its setup phase
    task automatic reg_write(input apb_pkg::apb_addr_t addr, input apb_pkg::apb_data_t data);
        row_t r;
        idle_cycles(1);
        r       = blank_row();
        r.op    = OP_WRITE;
        r.addr  = addr;
        r.wdata = data;
        rows.push_back(r);
    endtask

    task automatic reg_read(input apb_pkg::apb_addr_t addr, input logic [1:0] op,
                            input apb_pkg::apb_data_t exp, input logic exp_err);
        row_t r;
        idle_cycles(1);
        r         = blank_row();
        r.op      = op;
        r.addr    = addr;
        r.exp     = exp;
        r.exp_err = exp_err;
        rows.push_back(r);
    endtask

    function automatic apb_pkg::apb_data_t model_reg_value(input apb_pkg::apb_addr_t addr);
        apb_pkg::apb_data_t v;
        v = '0;
        case (addr)
            apb_pkg::REG_CTRL:   v = apb_pkg::apb_data_t'(m_en);
            apb_pkg::REG_STATUS: v = apb_pkg::apb_data_t'(m_ovf);
            apb_pkg::REG_LEVEL: begin
                for (int i = 0; i < NC; i++) begin
                    v[4*i +: 4] = m_cnt[i][3:0];
                end
            end
            apb_pkg::REG_POPS:   v = m_pops;
            default:             v = '0;
        endcase
        return v;
    endfunction

    // one clock edge of the reference model
    task automatic model_step(input row_t r);
        arb_cfg_pkg::chan_t p;
        int                 i;
        p         = m_ptr;
        exp_valid = (m_cnt[p] != 0) && m_en[p] && !r.wen[p];
        if (exp_valid) begin
            exp_data  = m_buf[p][m_head[p]];
            exp_chan  = p;
            m_head[p] = (m_head[p] + 1) % DEPTH;
            m_cnt[p]  = m_cnt[p] - 1;
            m_pops    = m_pops + 1;
        end
        if (r.op == OP_WRITE && r.addr == apb_pkg::REG_CTRL) begin
            m_en = r.wdata[NC-1:0];
        end
        if (r.op == OP_WRITE && r.addr == apb_pkg::REG_STATUS) begin
            m_ovf = m_ovf & ~r.wdata[NC-1:0];
        end
        for (i = 0; i < NC; i++) begin
            if (r.wen[i]) begin
                if (m_cnt[i] < DEPTH) begin
                    m_buf[i][(m_head[i] + m_cnt[i]) % DEPTH] = r.din[8*i +: 8];
                    m_cnt[i] = m_cnt[i] + 1;
                end else begin
                    m_ovf[i] = 1'b1; // full queue drops the byte
                end
            end
        end
        m_ptr = m_ptr + 1'b1;
    endtask

    task automatic drive_row(input int k);
        row_t r;
        row_t nx;
        r     = rows[k];
        wen   = r.wen;
        din_0 = r.din[7:0];
        din_1 = r.din[15:8];
        din_2 = r.din[23:16];
        din_3 = r.din[31:24];
        if (r.op != OP_NONE) begin
            psel    = 1'b1;
            penable = 1'b1;
            pwrite  = (r.op == OP_WRITE);
            paddr   = r.addr;
            pwdata  = r.wdata;
        end else if (k + 1 < rows.size() && rows[k+1].op != OP_NONE) begin
            nx      = rows[k+1];
            psel    = 1'b1; // setup phase of the next access
            penable = 1'b0;
            pwrite  = (nx.op == OP_WRITE);
            paddr   = nx.addr;
            pwdata  = nx.wdata;
        end else begin
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: the test did not finish within %0d cycles", max_cycles);
            fail_now();
        end
    end

    initial begin
        apb_pkg::apb_data_t exp_rd;
        clk = 1'b0;
        rst_n = 1'b0;
        wen = '0;
        din_0 = '0;
        din_1 = '0;
        din_2 = '0;
        din_3 = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        errors = 0;
        cycle_cnt = 0;
        void'($urandom(12));
        for (int i = 0; i < NC; i++) begin
            m_head[i] = 0;
            m_cnt[i]  = 0;
        end
        m_ptr = '0;
        m_en = '1;
        m_ovf = '0;
        m_pops = '0;
        exp_valid = 1'b0;
        exp_data = '0;
        exp_chan = '0;

        // reset values and an unmapped address
        reg_read(apb_pkg::REG_CTRL, OP_READ_FIX, 32'h0000_000F, 1'b0);
        reg_read(apb_pkg::REG_STATUS, OP_READ_FIX, 32'h0, 1'b0);
        reg_read(apb_pkg::REG_LEVEL, OP_READ_FIX, 32'h0, 1'b0);
        reg_read(apb_pkg::REG_POPS, OP_READ_FIX, 32'h0, 1'b0);
        reg_read(8'h10, OP_READ_FIX, 32'h0, 1'b1);
        // single channel stream on channel 1
        write_burst(4'b0010, 5);
        idle_cycles(24);
        // writers on all channels lose their turn
        write_burst(4'b1111, 4);
        random_writes(4);
        idle_cycles(36);
        // overflow on a disabled channel 2
        reg_write(apb_pkg::REG_CTRL, 32'h0000_000B);
        write_burst(4'b0100, 10);
        reg_read(apb_pkg::REG_LEVEL, OP_READ, '0, 1'b0);
        reg_read(apb_pkg::REG_STATUS, OP_READ, '0, 1'b0);
        reg_write(apb_pkg::REG_STATUS, 32'h0000_0004);
        reg_read(apb_pkg::REG_STATUS, OP_READ, '0, 1'b0);
        // re-enable and drain
        reg_write(apb_pkg::REG_CTRL, 32'h0000_000F);
        idle_cycles(36);
        reg_read(apb_pkg::REG_POPS, OP_READ, '0, 1'b0);
        idle_cycles(4);

        max_cycles = rows.size() + RST_CYCLES + 50;

        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        for (int k = 0; k < rows.size(); k++) begin
            drive_row(k);
            #1;
            if (pslverr !== rows[k].exp_err) begin
                $display("pslverr was %0b in table row %0d where %0b was expected",
                         pslverr, k, rows[k].exp_err);
                fail_now();
            end
            if (rows[k].op != OP_NONE) begin
                check_valid("pready", pready, 1'b1);
            end
            if (rows[k].op == OP_READ || rows[k].op == OP_READ_FIX) begin
                exp_rd = (rows[k].op == OP_READ_FIX) ? rows[k].exp :
                         model_reg_value(rows[k].addr);
                check_apb("prdata", prdata, exp_rd);
            end
            model_step(rows[k]);
            @(negedge clk);
            check_valid("out_valid", out_valid, exp_valid);
            if (exp_valid) begin
                check_data("out_data", out_data, exp_data);
                check_chan("out_chan", out_chan, exp_chan);
            end
        end

        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
